// ==== include/box_cfg.svh ====
// **********************************************************
// Box filter configuration
// Image, kernel and pipeline dimensions shared by all blocks
// **********************************************************

`ifndef BOX_CFG_SVH
`define BOX_CFG_SVH

// Pixel format
`define BOX_DATA_WIDTH    8
`define BOX_COMPONENTS    3

// Kernel geometry and coefficient format
`define BOX_ROWS          3
`define BOX_COLS          3
`define BOX_COEFF_WIDTH   18
`define BOX_COEFF_FRAC    8

`define BOX_MAX_COLS      64
`define BOX_CALC_LATENCY  6

`endif

// ==== rtl/box_pkg.sv ====
// **********************************************************
// Box filter types
// Pixel, window, kernel and stream control definitions
// **********************************************************

`include "box_cfg.svh"

package box_pkg;

    // One colour component and the full pixel
    typedef logic [`BOX_DATA_WIDTH-1:0] data_t;
    typedef data_t [`BOX_COMPONENTS-1:0] pixel_t;

    // Neighbourhood indexed [row][col], row 0 on top and col 0 on the left
    typedef pixel_t [`BOX_ROWS-1:0][`BOX_COLS-1:0] window_t;
    typedef data_t [`BOX_ROWS-1:0][`BOX_COLS-1:0] lane_window_t;

    // Signed fixed point coefficients with BOX_COEFF_FRAC fraction bits
    typedef logic signed [`BOX_COEFF_WIDTH-1:0] coeff_t;
    typedef coeff_t [`BOX_ROWS-1:0][`BOX_COLS-1:0] kernel_t;
    typedef kernel_t [`BOX_COMPONENTS-1:0] kernel_set_t;

    typedef struct packed {
        logic row_first;
        logic row_last;
        logic col_first;
        logic col_last;
        logic de;
        logic valid;
    } img_ctrl_t;

endpackage

// ==== rtl/box_window_buffer.sv ====
// **********************************************************
// Box filter window buffer
// Two line memories and a 3x3 register window that build
// edge-replicated neighbourhoods one row and column behind
// **********************************************************

`timescale 1ns/10ps

`include "box_cfg.svh"

module box_window_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cke,
    input  box_pkg::img_ctrl_t    s_img,
    input  box_pkg::pixel_t       s_img_data,
    output box_pkg::img_ctrl_t    win_ctrl,
    output box_pkg::window_t      win_data
);

    localparam int ADDR_W = $clog2(`BOX_MAX_COLS);

    // Row r-1 with its markers, and row r-2
    box_pkg::pixel_t              mem_mid  [`BOX_MAX_COLS];
    box_pkg::img_ctrl_t           mem_ctrl [`BOX_MAX_COLS];
    box_pkg::pixel_t              mem_top  [`BOX_MAX_COLS];

    logic [ADDR_W-1:0]            col_cnt;
    logic [ADDR_W-1:0]            last_col;
    logic [ADDR_W-1:0]            addr;
    logic [1:0]                   row_cnt;
    logic [1:0]                   row_sel;
    logic                         flushing;
    logic                         flush_tail;

    logic                         accept;
    logic                         flush_step;
    logic                         step;
    logic                         first;
    logic                         second;
    logic                         fire;

    box_pkg::pixel_t              v_top;
    box_pkg::pixel_t              v_mid;
    box_pkg::pixel_t              v_bot;
    box_pkg::img_ctrl_t           v_ctrl;
    box_pkg::img_ctrl_t           ctrl_c;
    box_pkg::img_ctrl_t           ctrl_pend;
    box_pkg::img_ctrl_t           centre_ctrl;
    box_pkg::pixel_t [2:0]        pend_col;

    always_comb begin
        accept     = cke && s_img.valid;
        flush_step = cke && !s_img.valid && flushing;
        step       = accept || flush_step;

        addr  = (accept && s_img.col_first) ? '0 : col_cnt;
        first = accept ? s_img.col_first : (col_cnt == '0);
        second = !first && (addr == ADDR_W'(1));

        // Row index of the incoming column, saturated at 2
        if (flush_step) begin
            row_sel = 2'd2;
        end else if (s_img.row_first) begin
            row_sel = 2'd0;
        end else if (s_img.col_first && row_cnt != 2'd2) begin
            row_sel = row_cnt + 2'd1;
        end else begin
            row_sel = row_cnt;
        end

        // Vertical column centred one row up, replicated at the top and bottom edges
        v_mid  = mem_mid[addr];
        v_ctrl = mem_ctrl[addr];
        v_top  = (row_sel == 2'd1) ? v_mid : mem_top[addr];
        v_bot  = flush_step ? v_mid : s_img_data;

        centre_ctrl = second ? ctrl_pend : ctrl_c;

        // Nothing leaves until the centre row has a row below it
        fire = step && (row_sel != 2'd0) && !(row_sel == 2'd1 && first);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt    <= '0;
            row_cnt    <= '0;
            flushing   <= 1'b0;
            flush_tail <= 1'b0;
            win_ctrl   <= '0;
        end else if (cke) begin
            if (step) begin
                row_cnt <= row_sel;
                col_cnt <= addr + ADDR_W'(1);
            end
            if (accept) begin
                if (s_img.col_last) begin
                    col_cnt  <= '0;
                    last_col <= addr;
                    if (s_img.row_last) begin
                        flushing <= 1'b1;
                    end
                end
            end else if (flush_step) begin
                // One pass over the last row, then one beat for its right edge
                if (flush_tail) begin
                    flushing   <= 1'b0;
                    flush_tail <= 1'b0;
                    col_cnt    <= '0;
                end else if (addr == last_col) begin
                    flush_tail <= 1'b1;
                    col_cnt    <= '0;
                end
            end
            if (fire) begin
                win_ctrl       <= centre_ctrl;
                win_ctrl.valid <= 1'b1;
            end else begin
                win_ctrl.valid <= 1'b0;
                win_ctrl.de    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_mid[addr]  <= s_img_data;
            mem_ctrl[addr] <= s_img;
            mem_top[addr]  <= v_mid;
        end
        if (step) begin
            if (first) begin
                // Right edge of the previous row, new column 0 waits in pend_col
                pend_col  <= {v_bot, v_mid, v_top};
                ctrl_pend <= v_ctrl;
                for (int r = 0; r < 3; r++) begin
                    win_data[r][0] <= win_data[r][1];
                    win_data[r][1] <= win_data[r][2];
                end
            end else if (second) begin
                ctrl_c <= v_ctrl;
                for (int r = 0; r < 3; r++) begin
                    win_data[r][0] <= pend_col[r];
                    win_data[r][1] <= pend_col[r];
                end
                win_data[0][2] <= v_top;
                win_data[1][2] <= v_mid;
                win_data[2][2] <= v_bot;
            end else begin
                ctrl_c <= v_ctrl;
                for (int r = 0; r < 3; r++) begin
                    win_data[r][0] <= win_data[r][1];
                    win_data[r][1] <= win_data[r][2];
                end
                win_data[0][2] <= v_top;
                win_data[1][2] <= v_mid;
                win_data[2][2] <= v_bot;
            end
        end
    end

endmodule

// ==== rtl/box_calc.sv ====
// **********************************************************
// Box filter calculation lane
// Multiply, adder tree, rounding and clamp for one component
// **********************************************************

`timescale 1ns/10ps

`include "box_cfg.svh"

module box_calc (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cke,
    input  box_pkg::kernel_t        kernel,
    input  box_pkg::data_t          param_min,
    input  box_pkg::data_t          param_max,
    input  box_pkg::lane_window_t   in_data,
    output box_pkg::data_t          out_data
);

    // Headroom for nine products of a 9-bit pixel and a full scale coefficient
    localparam int ACC_W = `BOX_DATA_WIDTH + `BOX_COEFF_WIDTH + 5;
    localparam int FRAC  = `BOX_COEFF_FRAC;

    logic signed [ACC_W-1:0] prod [`BOX_ROWS*`BOX_COLS];
    logic signed [ACC_W-1:0] lvl1 [5];
    logic signed [ACC_W-1:0] lvl2 [3];
    logic signed [ACC_W-1:0] lvl3 [2];
    logic signed [ACC_W-1:0] sum;
    logic signed [ACC_W-1:0] rounded;
    logic signed [ACC_W-1:0] lo;
    logic signed [ACC_W-1:0] hi;

    // Stage 1 registers the nine products
    always_ff @(posedge clk) begin
        if (cke) begin
            for (int r = 0; r < `BOX_ROWS; r++) begin
                for (int c = 0; c < `BOX_COLS; c++) begin
                    prod[r*`BOX_COLS+c] <= ACC_W'($signed({1'b0, in_data[r][c]}))
                                         * ACC_W'(kernel[r][c]);
                end
            end
        end
    end

    // Stages 2 to 5 form the tree 9 -> 5 -> 3 -> 2 -> 1
    always_ff @(posedge clk) begin
        if (cke) begin
            lvl1[0] <= prod[0] + prod[1];
            lvl1[1] <= prod[2] + prod[3];
            lvl1[2] <= prod[4] + prod[5];
            lvl1[3] <= prod[6] + prod[7];
            lvl1[4] <= prod[8];

            lvl2[0] <= lvl1[0] + lvl1[1];
            lvl2[1] <= lvl1[2] + lvl1[3];
            lvl2[2] <= lvl1[4];

            lvl3[0] <= lvl2[0] + lvl2[1];
            lvl3[1] <= lvl2[2];

            sum <= lvl3[0] + lvl3[1];
        end
    end

    always_comb begin
        // Round to nearest, halves going up
        rounded = (sum + (ACC_W'(1) <<< (FRAC - 1))) >>> FRAC;
        lo      = ACC_W'(param_min);
        hi      = ACC_W'(param_max);
    end

    // Stage 6 clamps into the programmed range
    always_ff @(posedge clk) begin
        if (rst) begin
            out_data <= '0;
        end else if (cke) begin
            if (rounded < lo) begin
                out_data <= param_min;
            end else if (rounded > hi) begin
                out_data <= param_max;
            end else begin
                out_data <= rounded[`BOX_DATA_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== rtl/box_ctrl_delay.sv ====
// **********************************************************
// Box filter control delay
// Holds frame markers back by the calc pipeline depth
// **********************************************************

`timescale 1ns/10ps

`include "box_cfg.svh"

module box_ctrl_delay (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cke,
    input  box_pkg::img_ctrl_t    s_ctrl,
    output box_pkg::img_ctrl_t    m_ctrl
);

    localparam int LATENCY = `BOX_CALC_LATENCY;

    box_pkg::img_ctrl_t stage [LATENCY];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Markers are don't care while valid is low
            for (int i = 0; i < LATENCY; i++) begin
                stage[i].valid <= 1'b0;
                stage[i].de    <= 1'b0;
            end
        end else if (cke) begin
            stage[0] <= s_ctrl;
            for (int i = 1; i < LATENCY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign m_ctrl = stage[LATENCY-1];

endmodule

// ==== rtl/box_filter_top.sv ====
// **********************************************************
// Box filter top
// Window buffer feeding one calc lane per component
// **********************************************************

`timescale 1ns/10ps

`include "box_cfg.svh"

module box_filter_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cke,
    input  box_pkg::kernel_set_t    param_coeff,
    input  box_pkg::data_t          param_min,
    input  box_pkg::data_t          param_max,
    input  box_pkg::img_ctrl_t      s_img,
    input  box_pkg::pixel_t         s_img_data,
    output box_pkg::img_ctrl_t      m_img,
    output box_pkg::pixel_t         m_img_data
);

    box_pkg::img_ctrl_t     win_ctrl;
    box_pkg::window_t       win_data;
    box_pkg::lane_window_t  lane_win [`BOX_COMPONENTS];

    box_window_buffer u_window_buffer (
        .clk        (clk),
        .rst        (rst),
        .cke        (cke),
        .s_img      (s_img),
        .s_img_data (s_img_data),
        .win_ctrl   (win_ctrl),
        .win_data   (win_data)
    );

    for (genvar c = 0; c < `BOX_COMPONENTS; c++) begin : g_lane
        // Pick this component out of every window position
        for (genvar r = 0; r < `BOX_ROWS; r++) begin : g_row
            for (genvar x = 0; x < `BOX_COLS; x++) begin : g_col
                assign lane_win[c][r][x] = win_data[r][x][c];
            end
        end

        box_calc u_calc (
            .clk       (clk),
            .rst       (rst),
            .cke       (cke),
            .kernel    (param_coeff[c]),
            .param_min (param_min),
            .param_max (param_max),
            .in_data   (lane_win[c]),
            .out_data  (m_img_data[c])
        );
    end

    box_ctrl_delay u_ctrl_delay (
        .clk    (clk),
        .rst    (rst),
        .cke    (cke),
        .s_ctrl (win_ctrl),
        .m_ctrl (m_img)
    );

endmodule

// ==== dv/box_checker.sv ====
// **********************************************************
// Box filter checker
// Concurrent assertions on framing, pixel values and stalls
// **********************************************************

`timescale 1ns/10ps

`include "box_cfg.svh"

module box_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  cke,
    input box_pkg::kernel_set_t  param_coeff,
    input box_pkg::data_t        param_min,
    input box_pkg::data_t        param_max,
    input box_pkg::img_ctrl_t    s_img,
    input box_pkg::pixel_t       s_img_data,
    input box_pkg::img_ctrl_t    m_img,
    input box_pkg::pixel_t       m_img_data
);

    localparam int FRAC = `BOX_COEFF_FRAC;

    int                  errors = 0;
    logic                seen_in = 1'b0;
    box_pkg::img_ctrl_t  ctrl_q [$];
    box_pkg::pixel_t     data_q [$];
    box_pkg::pixel_t     exp_data;
    box_pkg::pixel_t     flat_data;
    logic [4:0]          exp_mark;
    logic [4:0]          got_mark;
    logic                out_beat;
    logic                have_front;
    logic                is_ident;
    logic                is_neg;
    logic                is_pos;
    logic                neg_ok;
    logic                pos_ok;

    // Kernel applied to a frame of one value, rounded half up and clamped
    function automatic box_pkg::data_t flat_result(input box_pkg::data_t v,
                                                   input box_pkg::kernel_t k,
                                                   input box_pkg::data_t lo,
                                                   input box_pkg::data_t hi);
        longint acc;
        acc = 0;
        for (int r = 0; r < `BOX_ROWS; r++) begin
            for (int x = 0; x < `BOX_COLS; x++) begin
                acc += longint'(v) * longint'($signed(k[r][x]));
            end
        end
        acc = (acc + (longint'(1) << (FRAC - 1))) >>> FRAC;
        if (acc < longint'(lo)) return lo;
        if (acc > longint'(hi)) return hi;
        return box_pkg::data_t'(acc);
    endfunction

    always_comb begin
        out_beat   = !rst && cke && m_img.valid;
        have_front = ctrl_q.size() > 0;
        exp_data   = have_front ? data_q[0] : '0;
        exp_mark   = have_front ? {ctrl_q[0].row_first, ctrl_q[0].row_last,
                                   ctrl_q[0].col_first, ctrl_q[0].col_last,
                                   ctrl_q[0].de} : '0;
        got_mark   = {m_img.row_first, m_img.row_last, m_img.col_first, m_img.col_last,
                      m_img.de};
        is_ident   = param_min == 8'h00 && param_max == 8'hff;
        is_neg     = 1'b1;
        is_pos     = 1'b1;
        neg_ok     = 1'b1;
        pos_ok     = 1'b1;
        for (int c = 0; c < `BOX_COMPONENTS; c++) begin
            for (int r = 0; r < `BOX_ROWS; r++) begin
                for (int x = 0; x < `BOX_COLS; x++) begin
                    is_ident &= $signed(param_coeff[c][r][x])
                                == ((r == 1 && x == 1) ? (1 << FRAC) : 0);
                    is_neg &= $signed(param_coeff[c][r][x]) < 0;
                    is_pos &= $signed(param_coeff[c][r][x]) >= (1 << 16);
                end
            end
            flat_data[c] = flat_result(exp_data[c], param_coeff[c], param_min, param_max);
            neg_ok &= exp_data[c] == '0 || m_img_data[c] == param_min;
            pos_ok &= exp_data[c] == '0 || m_img_data[c] == param_max;
        end
    end

    // Reference copy of every accepted input beat, in raster order
    always @(posedge clk) begin
        if (rst) begin
            ctrl_q.delete();
            data_q.delete();
            seen_in <= 1'b0;
        end else begin
            if (cke && s_img.valid) begin
                ctrl_q.push_back(s_img);
                data_q.push_back(s_img_data);
                seen_in <= 1'b1;
            end
            if (out_beat && have_front) begin
                void'(ctrl_q.pop_front());
                void'(data_q.pop_front());
            end
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !seen_in |-> !m_img.valid && !m_img.de)
        else begin
            errors++;
            $error("error t=%0t m_img valid,de exp 00 got %b%b", $time,
                   $sampled(m_img.valid), $sampled(m_img.de));
        end

    a_order: assert property (@(posedge clk) out_beat |-> have_front)
        else begin
            errors++;
            $error("output beat at t=%0t has no matching input beat", $time);
        end

    a_marks: assert property (@(posedge clk) out_beat |-> got_mark == exp_mark)
        else begin
            errors++;
            $error("error t=%0t m_img markers exp %b got %b", $time,
                   $sampled(exp_mark), $sampled(got_mark));
        end

    a_ident: assert property (@(posedge clk) out_beat && is_ident |-> m_img_data == exp_data)
        else begin
            errors++;
            $error("error t=%0t m_img_data exp %h got %h", $time,
                   $sampled(exp_data), $sampled(m_img_data));
        end

    a_flat: assert property (@(posedge clk)
        out_beat && !is_ident && !is_neg && !is_pos |-> m_img_data == flat_data)
        else begin
            errors++;
            $error("error t=%0t m_img_data exp %h got %h", $time,
                   $sampled(flat_data), $sampled(m_img_data));
        end

    a_clamp: assert property (@(posedge clk)
        out_beat |-> (!is_neg || neg_ok) && (!is_pos || pos_ok))
        else begin
            errors++;
            $error("error t=%0t m_img_data clamp exp %h or %h got %h", $time,
                   $sampled(param_min), $sampled(param_max), $sampled(m_img_data));
        end

    a_hold: assert property (@(posedge clk)
        !rst && !cke |=> $stable(m_img) && $stable(m_img_data))
        else begin
            errors++;
            $error("output changed at t=%0t while cke was low", $time);
        end

endmodule

bind box_filter_top box_checker u_checker (.*);

// ==== dv/box_clk_gen.sv ====
// **********************************************************
// Box filter testbench clock and reset
// **********************************************************

`timescale 1ns/10ps

module box_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== dv/box_tb.sv ====
// **********************************************************
// Box filter testbench
// Random and flat frames through four kernel modes
// **********************************************************

`timescale 1ns/10ps

`include "box_cfg.svh"

module box_tb;

    localparam int W          = 8;
    localparam int H          = 6;
    localparam int NUM_FRAMES = 6;
    localparam int GAP        = 16;
    localparam int LIMIT      = NUM_FRAMES * (W * H + GAP) * 2;

    logic                  clk;
    logic                  rst;
    logic                  cke;
    box_pkg::kernel_set_t  param_coeff;
    box_pkg::data_t        param_min;
    box_pkg::data_t        param_max;
    box_pkg::img_ctrl_t    s_img;
    box_pkg::pixel_t       s_img_data;
    box_pkg::img_ctrl_t    m_img;
    box_pkg::pixel_t       m_img_data;
    logic [31:0]           lfsr_state;
    int                    cycles = 0;

    box_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    box_filter_top dut0 (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Same kernel on all three components
    task automatic set_kernel(input box_pkg::coeff_t centre, input box_pkg::coeff_t side,
                              input box_pkg::data_t lo, input box_pkg::data_t hi);
        box_pkg::kernel_set_t k;
        for (int c = 0; c < `BOX_COMPONENTS; c++) begin
            for (int r = 0; r < `BOX_ROWS; r++) begin
                for (int x = 0; x < `BOX_COLS; x++) begin
                    k[c][r][x] = (r == 1 && x == 1) ? centre : side;
                end
            end
        end
        param_coeff <= k;
        param_min   <= lo;
        param_max   <= hi;
    endtask

    task automatic send_frame(input bit flat, input box_pkg::data_t level);
        logic [31:0] pix;
        logic [31:0] en;
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                take_bits(24, pix);
                if (flat) pix = {8'h00, level, level, level};
                // cke drops on about one cycle in eight
                do begin
                    @(posedge clk);
                    take_bits(3, en);
                    cke        <= en != 0;
                    s_img      <= '{row_first: y == 0, row_last: y == H - 1,
                                    col_first: x == 0, col_last: x == W - 1,
                                    de: 1'b1, valid: 1'b1};
                    s_img_data <= pix[23:0];
                end while (en == 0);
            end
        end
        @(posedge clk);
        s_img <= '0;
        forever begin
            take_bits(3, en);
            cke <= en != 0;
            @(posedge clk);
            if (cke && m_img.valid && m_img.row_last && m_img.col_last) break;
        end
        repeat (GAP) begin
            take_bits(3, en);
            cke <= en != 0;
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("sim failed");
            $fatal(1, "timeout: run did not finish within %0d cycles", LIMIT);
        end else if (dut0.u_checker.errors != 0) begin
            $display("sim failed");
            $fatal(1, "an assertion in the checker failed");
        end
    end

    initial begin
        logic [31:0] v;
        lfsr_state = 32'h7b99;
        cke        = 1'b0;
        s_img      = '0;
        s_img_data = '0;
        set_kernel(18'sd256, 18'sd0, 8'd0, 8'd255);
        @(negedge rst);

        send_frame(1'b0, 8'd0);
        send_frame(1'b0, 8'd0);

        set_kernel(18'sd200, -18'sd12, 8'd10, 8'd240);
        take_bits(8, v);
        send_frame(1'b1, v[7:0]);
        take_bits(8, v);
        send_frame(1'b1, v[7:0]);

        set_kernel(-18'sd256, -18'sd256, 8'd16, 8'd255);
        send_frame(1'b0, 8'd0);

        set_kernel(18'sd65536, 18'sd65536, 8'd0, 8'd200);
        send_frame(1'b0, 8'd0);

        if (dut0.u_checker.errors == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "the checker counted %0d assertion failures", dut0.u_checker.errors);
        end
    end

endmodule

// ==== project.f ====
+incdir+include
rtl/box_pkg.sv
rtl/box_window_buffer.sv
rtl/box_calc.sv
rtl/box_ctrl_delay.sv
rtl/box_filter_top.sv
dv/box_checker.sv
dv/box_clk_gen.sv
dv/box_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the box filter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module box_tb \
    -f project.f \
    -o box_sim

# Assertion failures are counted by the checker and turned into a fatal by the testbench
./obj_dir/box_sim +verilator+error+limit+100
